// ==== hdl/periph_pkg.sv ====
// ------------------------------------------------
// Address map, register offsets and constants of the
// peripheral domain. Referenced by scoped names only.
// ------------------------------------------------
package periph_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // Peripheral window: upper address bits select the window, 11:8 the region
  localparam int unsigned WindowLsb   = 12;
  localparam int unsigned RegionLsb   = 8;
  localparam int unsigned RegionWidth = 4;
  localparam logic [AddrWidth-WindowLsb-1:0] PeriphBase = 20'h03000;

  localparam int unsigned NumPeriphs     = 3;
  localparam int unsigned PeriphIdxWidth = $clog2(NumPeriphs);
  localparam int unsigned PeriphSocCtrl  = 0;
  localparam int unsigned PeriphGpio     = 1;
  localparam int unsigned PeriphTimer    = 2;

  // Register offsets inside a region
  localparam logic [RegionLsb-1:0] SocBootAddrOff   = 8'h00;
  localparam logic [RegionLsb-1:0] SocFetchEnOff    = 8'h04;
  localparam logic [RegionLsb-1:0] GpioDirOff       = 8'h00;
  localparam logic [RegionLsb-1:0] GpioOutOff       = 8'h04;
  localparam logic [RegionLsb-1:0] GpioInOff        = 8'h08;
  localparam logic [RegionLsb-1:0] GpioIrqEnOff     = 8'h0C;
  localparam logic [RegionLsb-1:0] GpioIrqStatusOff = 8'h10;
  localparam logic [RegionLsb-1:0] TimerCountOff    = 8'h00;
  localparam logic [RegionLsb-1:0] TimerCompareOff  = 8'h04;
  localparam logic [RegionLsb-1:0] TimerCtrlOff     = 8'h08;
  localparam logic [RegionLsb-1:0] TimerStatusOff   = 8'h0C;

  localparam int unsigned GpioCount       = 16;
  localparam int unsigned NumExternalIrqs = 4;

  // Interrupt vector layout
  localparam int unsigned NumIrqs    = 16;
  localparam int unsigned IrqTimer   = 0;
  localparam int unsigned IrqGpio    = 1;
  localparam int unsigned IrqExtBase = 2;

  localparam logic [AddrWidth-1:0] BootAddrDefault = 32'h1000_0000;
  localparam logic [DataWidth-1:0] ErrRspData      = 32'hBADCAB1E;

endpackage

// ==== hdl/obi_pkg.sv ====
// ------------------------------------------------
// OBI request and response structs used between the
// demultiplexer and the peripheral subordinates
// ------------------------------------------------
package obi_pkg;

  typedef struct packed {
    logic                                 req;
    logic                                 we;
    logic [periph_pkg::DataWidth/8-1:0]   be;
    logic [periph_pkg::AddrWidth-1:0]     addr;
    logic [periph_pkg::DataWidth-1:0]     wdata;
  } obi_req_t;

  typedef struct packed {
    logic                                 gnt;
    logic                                 rvalid;
    logic [periph_pkg::DataWidth-1:0]     rdata;
    logic                                 err;
  } obi_rsp_t;

  // Expand byte enables into a bit mask, one byte lane per be bit
  function automatic logic [periph_pkg::DataWidth-1:0] be_mask(
    input logic [periph_pkg::DataWidth/8-1:0] be
  );
    logic [periph_pkg::DataWidth-1:0] mask;
    for (int i = 0; i < periph_pkg::DataWidth / 8; i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

endpackage

// ==== hdl/periph_demux.sv ====
// ------------------------------------------------
// Peripheral demultiplexer. Routes each OBI request by
// region index, returns responses in order and answers
// unmapped addresses with an error response.
// ------------------------------------------------
`timescale 1ns/100ps

module periph_demux (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  obi_pkg::obi_req_t                             req_i,
  output obi_pkg::obi_rsp_t                             rsp_o,
  output obi_pkg::obi_req_t [periph_pkg::NumPeriphs-1:0] periph_req_o,
  input  obi_pkg::obi_rsp_t [periph_pkg::NumPeriphs-1:0] periph_rsp_i
);

  logic                                   in_window;
  logic [periph_pkg::RegionWidth-1:0]     region;
  logic [periph_pkg::PeriphIdxWidth-1:0]  sel_idx;
  logic                                   addr_valid;
  logic                                   granted;

  logic [periph_pkg::PeriphIdxWidth-1:0]  rsp_idx_q;
  logic                                   err_valid_q;

  // ------------------------------------------------
  // Address decode
  // ------------------------------------------------
  assign in_window  = (req_i.addr[periph_pkg::AddrWidth-1:periph_pkg::WindowLsb]
                       == periph_pkg::PeriphBase);
  assign region     = req_i.addr[periph_pkg::RegionLsb +: periph_pkg::RegionWidth];
  assign sel_idx    = req_i.addr[periph_pkg::RegionLsb +: periph_pkg::PeriphIdxWidth];
  assign addr_valid = in_window && (region < periph_pkg::RegionWidth'(periph_pkg::NumPeriphs));

  // Only the selected peripheral sees req
  always_comb begin
    for (int i = 0; i < periph_pkg::NumPeriphs; i++) begin
      periph_req_o[i]     = req_i;
      periph_req_o[i].req = req_i.req && addr_valid &&
                            (sel_idx == periph_pkg::PeriphIdxWidth'(i));
    end
  end

  // ------------------------------------------------
  // Response path
  // ------------------------------------------------
  always_comb begin
    rsp_o = '0;
    // Error addresses are granted right away by the demux itself
    rsp_o.gnt = addr_valid ? periph_rsp_i[sel_idx].gnt : req_i.req;
    if (err_valid_q) begin
      rsp_o.rvalid = 1'b1;
      rsp_o.rdata  = periph_pkg::ErrRspData;
      rsp_o.err    = 1'b1;
    end else begin
      rsp_o.rvalid = periph_rsp_i[rsp_idx_q].rvalid;
      rsp_o.rdata  = periph_rsp_i[rsp_idx_q].rdata;
      rsp_o.err    = periph_rsp_i[rsp_idx_q].err;
    end
  end

  assign granted = req_i.req && rsp_o.gnt;

  // Remember who owns next cycle's response
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_idx_q   <= '0;
      err_valid_q <= 1'b0;
    end else begin
      err_valid_q <= granted && !addr_valid;
      if (granted && addr_valid) begin
        rsp_idx_q <= sel_idx;
      end
    end
  end

endmodule

// ==== hdl/soc_ctrl_regs.sv ====
// ------------------------------------------------
// SoC control registers: boot address and fetch enable,
// written and read over the peripheral OBI port
// ------------------------------------------------
`timescale 1ns/100ps

module soc_ctrl_regs (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  obi_pkg::obi_req_t                req_i,
  output obi_pkg::obi_rsp_t                rsp_o,
  input  logic                             fetch_en_i,
  output logic [periph_pkg::AddrWidth-1:0] boot_addr_o,
  output logic                             fetch_enable_o
);

  logic [periph_pkg::RegionLsb-1:0] reg_off;
  logic [periph_pkg::DataWidth-1:0] wmask;
  logic [periph_pkg::DataWidth-1:0] rd_word;
  logic                             wr_en;

  logic [periph_pkg::AddrWidth-1:0] boot_addr_q;
  logic                             fetch_en_q;
  logic                             rvalid_q;
  logic [periph_pkg::DataWidth-1:0] rdata_q;

  assign reg_off = req_i.addr[periph_pkg::RegionLsb-1:0];
  assign wmask   = obi_pkg::be_mask(req_i.be);
  assign wr_en   = req_i.req && req_i.we;

  always_comb begin
    rd_word = '0;
    case (reg_off)
      periph_pkg::SocBootAddrOff: rd_word = boot_addr_q;
      periph_pkg::SocFetchEnOff:  rd_word[0] = fetch_en_q;
      default:                    rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      boot_addr_q <= periph_pkg::BootAddrDefault;
      fetch_en_q  <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (wr_en && reg_off == periph_pkg::SocBootAddrOff) begin
        boot_addr_q <= (boot_addr_q & ~wmask) | (req_i.wdata & wmask);
      end
      if (wr_en && reg_off == periph_pkg::SocFetchEnOff && req_i.be[0]) begin
        fetch_en_q <= req_i.wdata[0];
      end
    end
  end

  // Read data, zero for writes
  always_ff @(posedge clk_i) begin
    rdata_q <= (req_i.req && !req_i.we) ? rd_word : '0;
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

  assign boot_addr_o    = boot_addr_q;
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

// ==== hdl/gpio_ctrl.sv ====
// ------------------------------------------------
// GPIO block with direction, output, synchronized input
// and rising-edge interrupts (status is write-1-to-clear)
// ------------------------------------------------
`timescale 1ns/100ps

module gpio_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  obi_pkg::obi_req_t                req_i,
  output obi_pkg::obi_rsp_t                rsp_o,
  input  logic [periph_pkg::GpioCount-1:0] gpio_i,
  output logic [periph_pkg::GpioCount-1:0] gpio_o,
  output logic [periph_pkg::GpioCount-1:0] gpio_out_en_o,
  output logic [periph_pkg::GpioCount-1:0] gpio_in_sync_o,
  output logic                             irq_o
);

  localparam int unsigned N = periph_pkg::GpioCount;

  logic [periph_pkg::RegionLsb-1:0] reg_off;
  logic [periph_pkg::DataWidth-1:0] wmask;
  logic [periph_pkg::DataWidth-1:0] rd_word;
  logic                             wr_en;
  logic [N-1:0]                     rise;
  logic [N-1:0]                     status_clr;

  logic [N-1:0] dir_q, out_q, irq_en_q, status_q;
  logic [N-1:0] sync1_q, sync2_q, sync_d_q;
  logic         rvalid_q;
  logic [periph_pkg::DataWidth-1:0] rdata_q;

  assign reg_off = req_i.addr[periph_pkg::RegionLsb-1:0];
  assign wmask   = obi_pkg::be_mask(req_i.be);
  assign wr_en   = req_i.req && req_i.we;

  // Edge seen on the synchronized input
  assign rise       = sync2_q & ~sync_d_q;
  assign status_clr = (wr_en && reg_off == periph_pkg::GpioIrqStatusOff) ?
                      (req_i.wdata[N-1:0] & wmask[N-1:0]) : '0;

  always_comb begin
    rd_word = '0;
    case (reg_off)
      periph_pkg::GpioDirOff:       rd_word[N-1:0] = dir_q;
      periph_pkg::GpioOutOff:       rd_word[N-1:0] = out_q;
      periph_pkg::GpioInOff:        rd_word[N-1:0] = sync2_q;
      periph_pkg::GpioIrqEnOff:     rd_word[N-1:0] = irq_en_q;
      periph_pkg::GpioIrqStatusOff: rd_word[N-1:0] = status_q;
      default:                      rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      {dir_q, out_q, irq_en_q, status_q} <= '0;
      {sync1_q, sync2_q, sync_d_q}       <= '0;
      rvalid_q <= 1'b0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      sync_d_q <= sync2_q;
      rvalid_q <= req_i.req;
      if (wr_en && reg_off == periph_pkg::GpioDirOff)
        dir_q <= (dir_q & ~wmask[N-1:0]) | (req_i.wdata[N-1:0] & wmask[N-1:0]);
      if (wr_en && reg_off == periph_pkg::GpioOutOff)
        out_q <= (out_q & ~wmask[N-1:0]) | (req_i.wdata[N-1:0] & wmask[N-1:0]);
      if (wr_en && reg_off == periph_pkg::GpioIrqEnOff)
        irq_en_q <= (irq_en_q & ~wmask[N-1:0]) | (req_i.wdata[N-1:0] & wmask[N-1:0]);
      // New edges win over a clear in the same cycle
      status_q <= (status_q & ~status_clr) | (rise & irq_en_q);
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= (req_i.req && !req_i.we) ? rd_word : '0;
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync2_q;
  assign irq_o          = |status_q;

endmodule

// ==== hdl/periph_timer.sv ====
// ------------------------------------------------
// Compare timer. Counts while enabled, wraps on a match
// with compare and sets a sticky expired flag (irq).
// ------------------------------------------------
`timescale 1ns/100ps

module periph_timer (
  input  logic              clk_i,
  input  logic              rst_i,
  input  obi_pkg::obi_req_t req_i,
  output obi_pkg::obi_rsp_t rsp_o,
  output logic              irq_o
);

  logic [periph_pkg::RegionLsb-1:0] reg_off;
  logic [periph_pkg::DataWidth-1:0] wmask;
  logic [periph_pkg::DataWidth-1:0] rd_word;
  logic                             wr_en;
  logic                             match;
  logic                             expired_clr;

  logic [periph_pkg::DataWidth-1:0] count_q;
  logic [periph_pkg::DataWidth-1:0] compare_q;
  logic                             enable_q;
  logic                             expired_q;
  logic                             rvalid_q;
  logic [periph_pkg::DataWidth-1:0] rdata_q;

  assign reg_off     = req_i.addr[periph_pkg::RegionLsb-1:0];
  assign wmask       = obi_pkg::be_mask(req_i.be);
  assign wr_en       = req_i.req && req_i.we;
  assign match       = enable_q && (count_q == compare_q);
  assign expired_clr = wr_en && reg_off == periph_pkg::TimerStatusOff &&
                       req_i.be[0] && req_i.wdata[0];

  always_comb begin
    rd_word = '0;
    case (reg_off)
      periph_pkg::TimerCountOff:   rd_word = count_q;
      periph_pkg::TimerCompareOff: rd_word = compare_q;
      periph_pkg::TimerCtrlOff:    rd_word[0] = enable_q;
      periph_pkg::TimerStatusOff:  rd_word[0] = expired_q;
      default:                     rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q   <= '0;
      compare_q <= '0;
      enable_q  <= 1'b0;
      expired_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      // A bus write to the counter overrides counting
      if (wr_en && reg_off == periph_pkg::TimerCountOff) begin
        count_q <= (count_q & ~wmask) | (req_i.wdata & wmask);
      end else if (match) begin
        count_q <= '0;
      end else if (enable_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr_en && reg_off == periph_pkg::TimerCompareOff)
        compare_q <= (compare_q & ~wmask) | (req_i.wdata & wmask);
      if (wr_en && reg_off == periph_pkg::TimerCtrlOff && req_i.be[0])
        enable_q <= req_i.wdata[0];
      expired_q <= match | (expired_q & ~expired_clr);
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= (req_i.req && !req_i.we) ? rd_word : '0;
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

  assign irq_o = expired_q;

endmodule

// ==== hdl/periph_domain.sv ====
// ------------------------------------------------
// Peripheral domain top level. One OBI port in, fanned
// out to control regs, GPIO and timer; builds irqs_o.
// ------------------------------------------------
`timescale 1ns/100ps

module periph_domain (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic                                   fetch_en_i,
  input  logic [periph_pkg::NumExternalIrqs-1:0] interrupts_i,
  input  logic [periph_pkg::GpioCount-1:0]       gpio_i,
  input  obi_pkg::obi_req_t                      req_i,
  output obi_pkg::obi_rsp_t                      rsp_o,
  output logic [periph_pkg::AddrWidth-1:0]       boot_addr_o,
  output logic                                   fetch_enable_o,
  output logic [periph_pkg::NumIrqs-1:0]         irqs_o,
  output logic [periph_pkg::GpioCount-1:0]       gpio_o,
  output logic [periph_pkg::GpioCount-1:0]       gpio_out_en_o,
  output logic [periph_pkg::GpioCount-1:0]       gpio_in_sync_o
);

  obi_pkg::obi_req_t [periph_pkg::NumPeriphs-1:0] periph_req;
  obi_pkg::obi_rsp_t [periph_pkg::NumPeriphs-1:0] periph_rsp;
  logic timer_irq;
  logic gpio_irq;

  // ------------------------------------------------
  // Interrupt vector
  // ------------------------------------------------
  always_comb begin
    irqs_o = '0;
    irqs_o[periph_pkg::IrqTimer] = timer_irq;
    irqs_o[periph_pkg::IrqGpio]  = gpio_irq;
    irqs_o[periph_pkg::IrqExtBase +: periph_pkg::NumExternalIrqs] = interrupts_i;
  end

  periph_demux i_demux (
    .clk_i,
    .rst_i,
    .req_i,
    .rsp_o,
    .periph_req_o ( periph_req ),
    .periph_rsp_i ( periph_rsp )
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i,
    .rst_i,
    .req_i          ( periph_req[periph_pkg::PeriphSocCtrl] ),
    .rsp_o          ( periph_rsp[periph_pkg::PeriphSocCtrl] ),
    .fetch_en_i,
    .boot_addr_o,
    .fetch_enable_o
  );

  gpio_ctrl i_gpio (
    .clk_i,
    .rst_i,
    .req_i          ( periph_req[periph_pkg::PeriphGpio] ),
    .rsp_o          ( periph_rsp[periph_pkg::PeriphGpio] ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o,
    .irq_o          ( gpio_irq )
  );

  periph_timer i_timer (
    .clk_i,
    .rst_i,
    .req_i ( periph_req[periph_pkg::PeriphTimer] ),
    .rsp_o ( periph_rsp[periph_pkg::PeriphTimer] ),
    .irq_o ( timer_irq )
  );

endmodule

// ==== verif/periph_domain_props.sv ====
// ------------------------------------------------
// Bus protocol assertions for the peripheral OBI port,
// bound into every periph_demux instance
// ------------------------------------------------
`timescale 1ns/100ps

module periph_domain_props (
  input logic              clk_i,
  input logic              rst_i,
  input obi_pkg::obi_req_t req_i,
  input obi_pkg::obi_rsp_t rsp_i
);

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_i.gnt |-> req_i.req)
    else $error("gnt high while req is low");

  // One-cycle response latency
  rvalid_after_grant: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_i.req && rsp_i.gnt) |=> rsp_i.rvalid)
    else $error("rvalid missing one cycle after a grant");

  rvalid_needs_grant: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_i.rvalid |-> $past(req_i.req && rsp_i.gnt))
    else $error("rvalid without a grant in the cycle before");

  err_with_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_i.err |-> rsp_i.rvalid)
    else $error("err high without rvalid");

endmodule

bind periph_demux periph_domain_props i_props (
  .clk_i ( clk_i ),
  .rst_i ( rst_i ),
  .req_i ( req_i ),
  .rsp_i ( rsp_o )
);

// ==== verif/periph_domain_tb.sv ====
// ------------------------------------------------
// Directed testbench for the peripheral domain. Drives
// the OBI port and pins, checks registers, GPIO, timer,
// error responses and back-to-back transfers.
// ------------------------------------------------
`timescale 1ns/100ps

module periph_domain_tb;

  localparam int unsigned ClkPeriod    = 100;
  localparam int unsigned ResetCycles  = 3;
  // Rough cycle budget per test, summed for the watchdog
  localparam int unsigned TestCycles   = 20 + 25 + 30 + 60 + 45 + 10;
  localparam int unsigned MarginCycles = 200;

  localparam logic [31:0] SocBase   = 32'h0300_0000;
  localparam logic [31:0] GpioBase  = 32'h0300_0100;
  localparam logic [31:0] TimerBase = 32'h0300_0200;

  logic              clk;
  logic              rst;
  logic              fetch_en;
  logic [3:0]        interrupts;
  logic [15:0]       gpio_in;
  obi_pkg::obi_req_t req;
  obi_pkg::obi_rsp_t rsp;
  logic [31:0]       boot_addr;
  logic              fetch_enable;
  logic [15:0]       irqs;
  logic [15:0]       gpio_out;
  logic [15:0]       gpio_out_en;
  logic [15:0]       gpio_in_sync;

  int unsigned errors;
  int unsigned checks;
  int unsigned tests;
  // Model of register contents written so far
  logic [31:0] exp_boot;
  logic [15:0] exp_dir;

  periph_domain i_dut (
    .clk_i          ( clk ),
    .rst_i          ( rst ),
    .fetch_en_i     ( fetch_en ),
    .interrupts_i   ( interrupts ),
    .gpio_i         ( gpio_in ),
    .req_i          ( req ),
    .rsp_o          ( rsp ),
    .boot_addr_o    ( boot_addr ),
    .fetch_enable_o ( fetch_enable ),
    .irqs_o         ( irqs ),
    .gpio_o         ( gpio_out ),
    .gpio_out_en_o  ( gpio_out_en ),
    .gpio_in_sync_o ( gpio_in_sync )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #((ResetCycles + TestCycles + MarginCycles) * ClkPeriod);
    $display("watchdog expired before the tests finished");
    $display("=== FAIL ===");
    $finish;
  end

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------
  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] be,
                            output logic [31:0] rdata, output logic err);
    int unsigned waits;
    logic        granted;
    rdata = '0;
    err   = 1'b0;
    waits = 0;
    @(posedge clk);
    req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    // gnt is combinational, look at it mid-cycle
    @(negedge clk);
    while (!rsp.gnt && waits < 8) begin
      @(negedge clk);
      waits++;
    end
    granted = rsp.gnt;
    @(posedge clk);
    req <= '0;
    if (!granted) begin
      errors++;
      $display("bus access to 0x%h was never granted", addr);
    end else begin
      @(negedge clk);
      if (!rsp.rvalid) begin
        errors++;
        $display("no response in the cycle after the grant for 0x%h", addr);
      end
      rdata = rsp.rdata;
      err   = rsp.err;
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, addr, wdata, be, rdata, err);
    check_eq("rsp err (write)", 32'(err), 32'd0);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    logic err;
    bus_access(1'b0, addr, 32'd0, 4'hF, rdata, err);
    check_eq("rsp err (read)", 32'(err), 32'd0);
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    tests++;
    $display("test %s: %s", name, (errors == errs_before) ? "ok" : "failed");
  endtask

  // ------------------------------------------------
  // Directed tests
  // ------------------------------------------------
  task automatic test_reset_state();
    int unsigned start;
    logic [31:0] data;
    start = errors;
    check_eq("boot_addr_o", boot_addr, 32'h1000_0000);
    bus_read(SocBase, data);
    check_eq("boot address register", data, 32'h1000_0000);
    @(posedge clk);
    fetch_en <= 1'b1;
    @(negedge clk);
    check_eq("fetch_enable_o", 32'(fetch_enable), 32'd1);
    @(posedge clk);
    fetch_en <= 1'b0;
    @(negedge clk);
    check_eq("fetch_enable_o", 32'(fetch_enable), 32'd0);
    check_eq("gpio_out_en_o", 32'(gpio_out_en), 32'd0);
    check_eq("gpio_o", 32'(gpio_out), 32'd0);
    check_eq("irqs_o", 32'(irqs), 32'd0);
    report_test("reset_state", start);
  endtask

  task automatic test_soc_ctrl();
    int unsigned start;
    logic [31:0] wdata;
    logic [31:0] mask;
    logic [31:0] data;
    logic [3:0]  be;
    start = errors;
    wdata = $urandom;
    be    = 4'b0101;
    mask  = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    exp_boot = (exp_boot & ~mask) | (wdata & mask);
    bus_write(SocBase, wdata, be);
    check_eq("boot_addr_o", boot_addr, exp_boot);
    bus_read(SocBase, data);
    check_eq("boot address register", data, exp_boot);
    // Register alone raises fetch enable
    bus_write(SocBase + 32'h4, 32'd1, 4'hF);
    check_eq("fetch_enable_o", 32'(fetch_enable), 32'd1);
    bus_read(SocBase + 32'h4, data);
    check_eq("fetch enable register", data, 32'd1);
    bus_write(SocBase + 32'h4, 32'd0, 4'hF);
    check_eq("fetch_enable_o", 32'(fetch_enable), 32'd0);
    report_test("soc_ctrl", start);
  endtask

  task automatic test_error_rsp();
    int unsigned start;
    logic [31:0] data;
    logic        err;
    start = errors;
    bus_access(1'b0, 32'h0400_0000, 32'd0, 4'hF, data, err);
    check_eq("rsp err (outside window)", 32'(err), 32'd1);
    check_eq("rsp rdata (outside window)", data, 32'hBADC_AB1E);
    bus_access(1'b0, 32'h0300_0300, 32'd0, 4'hF, data, err);
    check_eq("rsp err (region 3)", 32'(err), 32'd1);
    check_eq("rsp rdata (region 3)", data, 32'hBADC_AB1E);
    bus_access(1'b1, 32'h0300_0300, $urandom, 4'hF, data, err);
    check_eq("rsp err (region 3 write)", 32'(err), 32'd1);
    // Low address bits of these match boot address, GPIO direction and timer compare
    bus_access(1'b1, 32'h0400_0000, $urandom, 4'hF, data, err);
    check_eq("rsp err (outside window write)", 32'(err), 32'd1);
    bus_access(1'b1, 32'h0300_0500, $urandom, 4'hF, data, err);
    check_eq("rsp err (region 5 write)", 32'(err), 32'd1);
    bus_access(1'b1, 32'h0400_0204, $urandom, 4'hF, data, err);
    check_eq("rsp err (outside window write)", 32'(err), 32'd1);
    bus_read(SocBase, data);
    check_eq("boot address register", data, exp_boot);
    bus_read(GpioBase, data);
    check_eq("gpio direction register", data, {16'h0, exp_dir});
    bus_read(TimerBase + 32'h4, data);
    check_eq("timer compare register", data, 32'd0);
    report_test("error_rsp", start);
  endtask

  task automatic test_gpio();
    int unsigned start;
    int unsigned pin;
    logic [31:0] data;
    logic [15:0] out_val;
    logic [15:0] in_val;
    logic [15:0] pin_mask;
    logic [3:0]  ext;
    start = errors;
    exp_dir = 16'($urandom);
    out_val = 16'($urandom);
    bus_write(GpioBase, {16'h0, exp_dir}, 4'hF);
    bus_write(GpioBase + 32'h4, {16'h0, out_val}, 4'hF);
    check_eq("gpio_out_en_o", 32'(gpio_out_en), 32'(exp_dir));
    check_eq("gpio_o", 32'(gpio_out), 32'(out_val));
    // Input goes through two flops
    in_val = 16'($urandom);
    @(posedge clk);
    gpio_in <= in_val;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_eq("gpio_in_sync_o", 32'(gpio_in_sync), 32'(in_val));
    bus_read(GpioBase + 32'h8, data);
    check_eq("gpio input register", data, 32'(in_val));
    // Rising edge on one enabled pin
    pin      = $urandom % 16;
    pin_mask = 16'(32'd1 << pin);
    @(posedge clk);
    gpio_in <= '0;
    repeat (3) @(posedge clk);
    bus_write(GpioBase + 32'hC, 32'(pin_mask), 4'hF);
    @(posedge clk);
    gpio_in <= pin_mask;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_eq("irqs_o gpio bit", 32'(irqs[1]), 32'd1);
    bus_read(GpioBase + 32'h10, data);
    check_eq("gpio irq status", data, 32'(pin_mask));
    bus_write(GpioBase + 32'h10, 32'(pin_mask), 4'hF);
    check_eq("irqs_o gpio bit", 32'(irqs[1]), 32'd0);
    bus_read(GpioBase + 32'h10, data);
    check_eq("gpio irq status", data, 32'd0);
    // External lines land at bits 5:2
    ext = 4'($urandom);
    @(posedge clk);
    interrupts <= ext;
    @(negedge clk);
    check_eq("irqs_o", 32'(irqs), {26'h0, ext, 2'b00});
    @(posedge clk);
    interrupts <= '0;
    report_test("gpio", start);
  endtask

  task automatic test_timer();
    int unsigned start;
    int unsigned n;
    int unsigned waited;
    logic [31:0] data;
    start  = errors;
    n      = 2 + $urandom % 6;
    waited = 0;
    bus_write(TimerBase + 32'h4, n, 4'hF);
    bus_write(TimerBase, 32'd0, 4'hF);
    bus_write(TimerBase + 32'h8, 32'd1, 4'hF);
    while (!irqs[0] && waited < n + 4) begin
      @(negedge clk);
      waited++;
    end
    if (!irqs[0]) begin
      errors++;
      $display("timer irq did not rise within %0d cycles", n + 4);
    end
    // Stop first so a new match cannot set the flag again
    bus_write(TimerBase + 32'h8, 32'd0, 4'hF);
    bus_read(TimerBase + 32'hC, data);
    check_eq("timer status", data, 32'd1);
    bus_write(TimerBase + 32'hC, 32'd1, 4'hF);
    check_eq("irqs_o timer bit", 32'(irqs[0]), 32'd0);
    bus_read(TimerBase + 32'hC, data);
    check_eq("timer status", data, 32'd0);
    report_test("timer", start);
  endtask

  task automatic test_back_to_back();
    int unsigned start;
    start = errors;
    @(posedge clk);
    req <= '{req: 1'b1, we: 1'b0, be: 4'hF, addr: SocBase, wdata: 32'd0};
    @(negedge clk);
    check_eq("rsp gnt (first)", 32'(rsp.gnt), 32'd1);
    @(posedge clk);
    req <= '{req: 1'b1, we: 1'b0, be: 4'hF, addr: GpioBase, wdata: 32'd0};
    @(negedge clk);
    check_eq("rsp gnt (second)", 32'(rsp.gnt), 32'd1);
    check_eq("rsp rvalid (first)", 32'(rsp.rvalid), 32'd1);
    check_eq("rsp rdata (first)", rsp.rdata, exp_boot);
    @(posedge clk);
    req <= '0;
    @(negedge clk);
    check_eq("rsp rvalid (second)", 32'(rsp.rvalid), 32'd1);
    check_eq("rsp rdata (second)", rsp.rdata, {16'h0, exp_dir});
    report_test("back_to_back", start);
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin
    void'($urandom(32'ha0ad2649));
    rst        = 1'b1;
    fetch_en   = 1'b0;
    interrupts = '0;
    gpio_in    = '0;
    req        = '0;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    exp_boot   = 32'h1000_0000;
    exp_dir    = '0;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    test_reset_state();
    test_soc_ctrl();
    test_error_rsp();
    test_gpio();
    test_timer();
    test_back_to_back();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== project.f ====
hdl/periph_pkg.sv
hdl/obi_pkg.sv
hdl/periph_demux.sv
hdl/soc_ctrl_regs.sv
hdl/gpio_ctrl.sv
hdl/periph_timer.sv
hdl/periph_domain.sv
verif/periph_domain_props.sv
verif/periph_domain_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; success only if the pass line appears in the output
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal --top-module periph_domain_tb \
       -f project.f -o periph_domain_sim \
  && ./obj_dir/periph_domain_sim | tee /dev/stderr | grep -qx '=== PASS ===' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
